/* hdl/core_settings.svh */
`ifndef CORE_SETTINGS_SVH
`define CORE_SETTINGS_SVH

// first fetch address out of reset
`define RESET_PC 32'h0000_0000

// base opcodes of the kept subset
`define OPC_OP     7'b0110011
`define OPC_OPIMM  7'b0010011
`define OPC_LUI    7'b0110111
`define OPC_LOAD   7'b0000011
`define OPC_STORE  7'b0100011
`define OPC_BRANCH 7'b1100011
`define OPC_JAL    7'b1101111

// funct3 codes
`define F3_ADD_SUB 3'b000
`define F3_SLT     3'b010
`define F3_XOR     3'b100
`define F3_OR      3'b110
`define F3_AND     3'b111
`define F3_WORD    3'b010
`define F3_BEQ     3'b000
`define F3_BNE     3'b001

// funct7 codes
`define F7_BASE    7'b0000000
`define F7_SUB     7'b0100000

// full ebreak word, matched exactly
`define EBREAK_WORD 32'h0010_0073

`endif

/* hdl/core_pkg.sv */
`default_nettype none

package core_pkg;

	// data, address and instruction word
	typedef logic [31:0] word_t;

	// register index x0..x31
	typedef logic [4:0] reg_addr_t;

	// alu operations, pass_b feeds lui
	typedef enum logic [2:0] {
		alu_add,
		alu_sub,
		alu_and,
		alu_or,
		alu_xor,
		alu_slt,
		alu_pass_b
	} alu_op_e;

	// data memory access kind
	typedef enum logic [1:0] {
		mem_none,
		mem_load,
		mem_store
	} mem_op_e;

	// control flow kind
	typedef enum logic [1:0] {
		br_none,
		br_beq,
		br_bne,
		br_jal
	} br_kind_e;

	// fetch sequencer states
	typedef enum logic [2:0] {
		fs_idle,
		fs_fetch,
		fs_issue,
		fs_wait_retire,
		fs_halted
	} fetch_state_e;

	// load/store and writeback states
	typedef enum logic [1:0] {
		ls_idle,
		ls_mem_wait,
		ls_retire
	} lsu_state_e;

endpackage

`default_nettype wire

/* hdl/fetch_unit.sv */
`timescale 1ns/10ps
`default_nettype none
`include "core_settings.svh"

module fetch_unit import core_pkg::*; (
	input  logic  clock_i,
	input  logic  reset_i,
	output logic  inst_req_o,
	output word_t inst_addr_o,
	input  logic  inst_valid_i,
	input  word_t inst_rdata_i,
	input  logic  retire_i,
	input  logic  taken_i,
	input  word_t target_i,
	input  logic  halt_i,
	output logic  issue_o,
	output word_t inst_o,
	output word_t pc_o,
	output logic  halted_o
);

	fetch_state_e state_q;
	word_t        pc_q;
	word_t        inst_q;
	word_t        pc_plus4;

	assign pc_plus4 = pc_q + 32'd4;

	// sequencer: one instruction in flight, next fetch only after retire
	always_ff @(posedge clock_i) begin
		if (reset_i) begin
			state_q <= fs_idle;
			pc_q    <= `RESET_PC;
		end else begin
			case (state_q)
				// leave idle one cycle after reset drops
				fs_idle: begin
					state_q <= fs_fetch;
				end
				// hold request and address until memory answers
				fs_fetch: begin
					if (inst_valid_i) begin
						state_q <= fs_issue;
					end
				end
				// ebreak parks the core here
				fs_issue: begin
					if (halt_i) begin
						state_q <= fs_halted;
					end else begin
						state_q <= fs_wait_retire;
					end
				end
				// branch outcome comes with the retire pulse
				fs_wait_retire: begin
					if (retire_i) begin
						pc_q    <= taken_i ? target_i : pc_plus4;
						state_q <= fs_fetch;
					end
				end
				fs_halted: begin
					state_q <= fs_halted;
				end
				default: begin
					state_q <= fs_idle;
				end
			endcase
		end
	end

	// fetched word, held through issue
	always_ff @(posedge clock_i) begin
		if (state_q == fs_fetch && inst_valid_i) begin
			inst_q <= inst_rdata_i;
		end
	end

	assign inst_req_o  = (state_q == fs_fetch);
	assign inst_addr_o = pc_q;
	// single cycle issue strobe
	assign issue_o     = (state_q == fs_issue);
	assign inst_o      = inst_q;
	assign pc_o        = pc_q;
	assign halted_o    = (state_q == fs_halted);

endmodule

`default_nettype wire

/* hdl/decoder.sv */
`timescale 1ns/10ps
`default_nettype none
`include "core_settings.svh"

module decoder import core_pkg::*; (
	input  word_t     inst_i,
	output reg_addr_t rs1_addr_o,
	output reg_addr_t rs2_addr_o,
	output reg_addr_t rd_addr_o,
	output logic      rd_wen_o,
	output word_t     imm_o,
	output logic      use_imm_o,
	output alu_op_e   alu_op_o,
	output mem_op_e   mem_op_o,
	output br_kind_e  br_kind_o,
	output logic      halt_o
);

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	word_t      imm_i_fmt;
	word_t      imm_s_fmt;
	word_t      imm_b_fmt;
	word_t      imm_u_fmt;
	word_t      imm_j_fmt;

	// fixed field positions
	assign opcode     = inst_i[6:0];
	assign funct3     = inst_i[14:12];
	assign funct7     = inst_i[31:25];
	assign rd_addr_o  = inst_i[11:7];
	assign rs1_addr_o = inst_i[19:15];
	assign rs2_addr_o = inst_i[24:20];

	// immediates, sign taken from bit 31
	assign imm_i_fmt = {{20{inst_i[31]}}, inst_i[31:20]};
	assign imm_s_fmt = {{20{inst_i[31]}}, inst_i[31:25], inst_i[11:7]};
	assign imm_b_fmt = {{19{inst_i[31]}}, inst_i[31], inst_i[7], inst_i[30:25],
		inst_i[11:8], 1'b0};
	assign imm_u_fmt = {inst_i[31:12], 12'b0};
	assign imm_j_fmt = {{11{inst_i[31]}}, inst_i[31], inst_i[19:12], inst_i[20],
		inst_i[30:21], 1'b0};

	// exact match, ebreak has no free fields
	assign halt_o = (inst_i == `EBREAK_WORD);

	always_comb begin
		// defaults describe a no-op
		rd_wen_o  = 1'b0;
		imm_o     = imm_i_fmt;
		use_imm_o = 1'b0;
		alu_op_o  = alu_add;
		mem_op_o  = mem_none;
		br_kind_o = br_none;
		case (opcode)
			`OPC_OP: begin
				rd_wen_o = 1'b1;
				case (funct3)
					`F3_ADD_SUB: begin
						if (funct7 == `F7_SUB) begin
							alu_op_o = alu_sub;
						end else if (funct7 != `F7_BASE) begin
							rd_wen_o = 1'b0;
						end
					end
					`F3_AND: alu_op_o = alu_and;
					`F3_OR:  alu_op_o = alu_or;
					`F3_XOR: alu_op_o = alu_xor;
					`F3_SLT: alu_op_o = alu_slt;
					// shifts and sltu are outside the subset
					default: rd_wen_o = 1'b0;
				endcase
			end
			`OPC_OPIMM: begin
				// addi only
				rd_wen_o  = (funct3 == `F3_ADD_SUB);
				use_imm_o = 1'b1;
			end
			`OPC_LUI: begin
				rd_wen_o  = 1'b1;
				imm_o     = imm_u_fmt;
				use_imm_o = 1'b1;
				alu_op_o  = alu_pass_b;
			end
			`OPC_LOAD: begin
				// lw, address is rs1 plus imm
				if (funct3 == `F3_WORD) begin
					rd_wen_o  = 1'b1;
					use_imm_o = 1'b1;
					mem_op_o  = mem_load;
				end
			end
			`OPC_STORE: begin
				if (funct3 == `F3_WORD) begin
					imm_o     = imm_s_fmt;
					use_imm_o = 1'b1;
					mem_op_o  = mem_store;
				end
			end
			`OPC_BRANCH: begin
				// compare is done on rs1/rs2 directly in exec
				imm_o = imm_b_fmt;
				if (funct3 == `F3_BEQ) begin
					br_kind_o = br_beq;
				end else if (funct3 == `F3_BNE) begin
					br_kind_o = br_bne;
				end
			end
			`OPC_JAL: begin
				rd_wen_o  = 1'b1;
				imm_o     = imm_j_fmt;
				br_kind_o = br_jal;
			end
			default: begin
				rd_wen_o = 1'b0;
			end
		endcase
	end

endmodule

`default_nettype wire

/* hdl/register_file.sv */
`timescale 1ns/10ps
`default_nettype none

module register_file import core_pkg::*; (
	input  logic      clock_i,
	input  logic      reset_i,
	input  reg_addr_t rs1_addr_i,
	input  reg_addr_t rs2_addr_i,
	output word_t     rs1_data_o,
	output word_t     rs2_data_o,
	input  logic      wen_i,
	input  reg_addr_t waddr_i,
	input  word_t     wdata_i
);

	word_t regs [32];

	// whole file cleared on reset
	always_ff @(posedge clock_i) begin
		if (reset_i) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (wen_i && waddr_i != 5'd0) begin
			regs[waddr_i] <= wdata_i;
		end
	end

	// x0 always reads zero
	assign rs1_data_o = (rs1_addr_i == 5'd0) ? '0 : regs[rs1_addr_i];
	assign rs2_data_o = (rs2_addr_i == 5'd0) ? '0 : regs[rs2_addr_i];

endmodule

`default_nettype wire

/* hdl/exec_unit.sv */
`timescale 1ns/10ps
`default_nettype none

module exec_unit import core_pkg::*; (
	input  word_t    pc_i,
	input  word_t    rs1_data_i,
	input  word_t    rs2_data_i,
	input  word_t    imm_i,
	input  logic     use_imm_i,
	input  alu_op_e  alu_op_i,
	input  br_kind_e br_kind_i,
	output word_t    result_o,
	output logic     taken_o,
	output word_t    target_o
);

	word_t op_b;
	word_t alu_out;
	logic  regs_equal;

	// second operand: immediate or rs2
	assign op_b = use_imm_i ? imm_i : rs2_data_i;

	always_comb begin
		case (alu_op_i)
			alu_add:    alu_out = rs1_data_i + op_b;
			alu_sub:    alu_out = rs1_data_i - op_b;
			alu_and:    alu_out = rs1_data_i & op_b;
			alu_or:     alu_out = rs1_data_i | op_b;
			alu_xor:    alu_out = rs1_data_i ^ op_b;
			// signed compare
			alu_slt:    alu_out = {31'b0, $signed(rs1_data_i) < $signed(op_b)};
			alu_pass_b: alu_out = op_b;
			default:    alu_out = rs1_data_i + op_b;
		endcase
	end

	// jal links pc+4, everything else takes the alu
	// loads and stores use this as the address
	assign result_o = (br_kind_i == br_jal) ? pc_i + 32'd4 : alu_out;

	// branch compare always on the raw register values
	assign regs_equal = (rs1_data_i == rs2_data_i);

	always_comb begin
		case (br_kind_i)
			br_beq:  taken_o = regs_equal;
			br_bne:  taken_o = !regs_equal;
			br_jal:  taken_o = 1'b1;
			default: taken_o = 1'b0;
		endcase
	end

	// pc relative for both branches and jal
	assign target_o = pc_i + imm_i;

endmodule

`default_nettype wire

/* hdl/lsu_wb.sv */
`timescale 1ns/10ps
`default_nettype none

module lsu_wb import core_pkg::*; (
	input  logic      clock_i,
	input  logic      reset_i,
	input  logic      issue_i,
	input  mem_op_e   mem_op_i,
	input  word_t     result_i,
	input  word_t     store_data_i,
	input  reg_addr_t rd_addr_i,
	input  logic      rd_wen_i,
	input  logic      taken_i,
	input  word_t     target_i,
	output logic      data_req_o,
	output logic      data_we_o,
	output word_t     data_addr_o,
	output word_t     data_wdata_o,
	input  logic      data_valid_i,
	input  word_t     data_rdata_i,
	output logic      reg_wen_o,
	output reg_addr_t reg_waddr_o,
	output word_t     reg_wdata_o,
	output logic      retire_o,
	output logic      taken_o,
	output word_t     target_o
);

	lsu_state_e state_q;
	mem_op_e    mem_op_q;
	word_t      result_q;
	word_t      store_data_q;
	reg_addr_t  rd_addr_q;
	logic       rd_wen_q;
	logic       taken_q;
	word_t      target_q;
	word_t      load_data_q;

	// state: memory ops wait for valid, others retire next cycle
	always_ff @(posedge clock_i) begin
		if (reset_i) begin
			state_q <= ls_idle;
		end else begin
			case (state_q)
				ls_idle: begin
					if (issue_i) begin
						state_q <= (mem_op_i == mem_none) ? ls_retire : ls_mem_wait;
					end
				end
				ls_mem_wait: begin
					if (data_valid_i) begin
						state_q <= ls_retire;
					end
				end
				ls_retire: begin
					state_q <= ls_idle;
				end
				default: begin
					state_q <= ls_idle;
				end
			endcase
		end
	end

	// instruction results captured on issue
	always_ff @(posedge clock_i) begin
		if (state_q == ls_idle && issue_i) begin
			mem_op_q     <= mem_op_i;
			result_q     <= result_i;
			store_data_q <= store_data_i;
			rd_addr_q    <= rd_addr_i;
			rd_wen_q     <= rd_wen_i;
			taken_q      <= taken_i;
			target_q     <= target_i;
		end
	end

	// load data taken in the valid cycle
	always_ff @(posedge clock_i) begin
		if (state_q == ls_mem_wait && data_valid_i) begin
			load_data_q <= data_rdata_i;
		end
	end

	// request level held until valid
	assign data_req_o   = (state_q == ls_mem_wait);
	assign data_we_o    = data_req_o && (mem_op_q == mem_store);
	assign data_addr_o  = result_q;
	assign data_wdata_o = store_data_q;

	// writeback in the retire cycle only
	assign retire_o    = (state_q == ls_retire);
	assign reg_wen_o   = retire_o && rd_wen_q;
	assign reg_waddr_o = rd_addr_q;
	assign reg_wdata_o = (mem_op_q == mem_load) ? load_data_q : result_q;

	// fetch samples these with retire
	assign taken_o  = taken_q;
	assign target_o = target_q;

endmodule

`default_nettype wire

/* hdl/core_top.sv */
`timescale 1ns/10ps
`default_nettype none

module core_top import core_pkg::*; (
	input  logic  clock_i,
	input  logic  reset_i,
	// instruction port
	output logic  inst_req_o,
	output word_t inst_addr_o,
	input  logic  inst_valid_i,
	input  word_t inst_rdata_i,
	// data port
	output logic  data_req_o,
	output logic  data_we_o,
	output word_t data_addr_o,
	output word_t data_wdata_o,
	input  logic  data_valid_i,
	input  word_t data_rdata_i,
	output logic  halted_o
);

	// fetch to decode
	logic      issue;
	word_t     inst;
	word_t     pc;

	// decode outputs
	reg_addr_t rs1_addr;
	reg_addr_t rs2_addr;
	reg_addr_t rd_addr;
	logic      rd_wen;
	word_t     imm;
	logic      use_imm;
	alu_op_e   alu_op;
	mem_op_e   mem_op;
	br_kind_e  br_kind;
	logic      halt;

	// register read data
	word_t     rs1_data;
	word_t     rs2_data;

	// execute outputs
	word_t     ex_result;
	logic      ex_taken;
	word_t     ex_target;

	// writeback and retire
	logic      reg_wen;
	reg_addr_t reg_waddr;
	word_t     reg_wdata;
	logic      retire;
	logic      wb_taken;
	word_t     wb_target;

	fetch_unit u_fetch_unit (
		.clock_i      (clock_i),
		.reset_i      (reset_i),
		.inst_req_o   (inst_req_o),
		.inst_addr_o  (inst_addr_o),
		.inst_valid_i (inst_valid_i),
		.inst_rdata_i (inst_rdata_i),
		.retire_i     (retire),
		.taken_i      (wb_taken),
		.target_i     (wb_target),
		.halt_i       (halt),
		.issue_o      (issue),
		.inst_o       (inst),
		.pc_o         (pc),
		.halted_o     (halted_o)
	);

	decoder u_decoder (
		.inst_i     (inst),
		.rs1_addr_o (rs1_addr),
		.rs2_addr_o (rs2_addr),
		.rd_addr_o  (rd_addr),
		.rd_wen_o   (rd_wen),
		.imm_o      (imm),
		.use_imm_o  (use_imm),
		.alu_op_o   (alu_op),
		.mem_op_o   (mem_op),
		.br_kind_o  (br_kind),
		.halt_o     (halt)
	);

	register_file u_register_file (
		.clock_i    (clock_i),
		.reset_i    (reset_i),
		.rs1_addr_i (rs1_addr),
		.rs2_addr_i (rs2_addr),
		.rs1_data_o (rs1_data),
		.rs2_data_o (rs2_data),
		.wen_i      (reg_wen),
		.waddr_i    (reg_waddr),
		.wdata_i    (reg_wdata)
	);

	exec_unit u_exec_unit (
		.pc_i       (pc),
		.rs1_data_i (rs1_data),
		.rs2_data_i (rs2_data),
		.imm_i      (imm),
		.use_imm_i  (use_imm),
		.alu_op_i   (alu_op),
		.br_kind_i  (br_kind),
		.result_o   (ex_result),
		.taken_o    (ex_taken),
		.target_o   (ex_target)
	);

	// store data comes straight from rs2
	lsu_wb u_lsu_wb (
		.clock_i      (clock_i),
		.reset_i      (reset_i),
		.issue_i      (issue),
		.mem_op_i     (mem_op),
		.result_i     (ex_result),
		.store_data_i (rs2_data),
		.rd_addr_i    (rd_addr),
		.rd_wen_i     (rd_wen),
		.taken_i      (ex_taken),
		.target_i     (ex_target),
		.data_req_o   (data_req_o),
		.data_we_o    (data_we_o),
		.data_addr_o  (data_addr_o),
		.data_wdata_o (data_wdata_o),
		.data_valid_i (data_valid_i),
		.data_rdata_i (data_rdata_i),
		.reg_wen_o    (reg_wen),
		.reg_waddr_o  (reg_waddr),
		.reg_wdata_o  (reg_wdata),
		.retire_o     (retire),
		.taken_o      (wb_taken),
		.target_o     (wb_target)
	);

endmodule

`default_nettype wire

/* testbench/core_tb.sv */
`timescale 1ns/10ps
`default_nettype none
`include "core_settings.svh"

module core_tb import core_pkg::*; ();

	// word indices into the golden image
	localparam int PROG_WORDS  = 32;
	localparam int DATA_BASE   = 32;
	localparam int DATA_WORDS  = 4;
	localparam int REC_BASE    = 40;
	localparam int COUNT_INDEX = 63;
	localparam int MAX_RECORDS = 11;
	// cycle limits for the waits
	localparam int REQ_LIMIT   = 10;
	localparam int HALT_LIMIT  = 3000;
	localparam int IDLE_CYCLES = 20;

	logic  clock;
	logic  reset_i;
	logic  inst_req_o;
	word_t inst_addr_o;
	logic  inst_valid_i;
	word_t inst_rdata_i;
	logic  data_req_o;
	logic  data_we_o;
	word_t data_addr_o;
	word_t data_wdata_o;
	logic  data_valid_i;
	word_t data_rdata_i;
	logic  halted_o;

	word_t golden [0:63];
	word_t imem [0:PROG_WORDS-1];
	word_t dmem [0:63];

	// one latency generator per memory
	word_t inst_rng;
	word_t data_rng;
	logic  inst_busy;
	logic  data_busy;
	int    inst_left;
	int    data_left;
	int    inst_delay;
	int    data_delay;
	int    store_count;
	int    rec_count;
	int    cycles;

	core_top DUT (
		.clock_i      (clock),
		.reset_i      (reset_i),
		.inst_req_o   (inst_req_o),
		.inst_addr_o  (inst_addr_o),
		.inst_valid_i (inst_valid_i),
		.inst_rdata_i (inst_rdata_i),
		.data_req_o   (data_req_o),
		.data_we_o    (data_we_o),
		.data_addr_o  (data_addr_o),
		.data_wdata_o (data_wdata_o),
		.data_valid_i (data_valid_i),
		.data_rdata_i (data_rdata_i),
		.halted_o     (halted_o)
	);

	// 100 ns period
	always #50 clock = ~clock;

	function automatic word_t xorshift32(input word_t x);
		word_t y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	task automatic stop_with_error(input string msg);
		$display("%s", msg);
		$display("Done: errors found");
		$fatal(1);
	endtask

	task automatic report_mismatch(input string name, input word_t got, input word_t exp);
		stop_with_error($sformatf("ERR %s: got %h, expected %h", name, got, exp));
	endtask

	// next golden record against the store on the bus
	task automatic check_store();
		word_t exp_addr;
		word_t exp_data;
		assert (store_count < rec_count) else
			stop_with_error("store seen after the last golden record");
		exp_addr = golden[REC_BASE + 2 * store_count];
		exp_data = golden[REC_BASE + 2 * store_count + 1];
		assert (data_addr_o == exp_addr) else
			report_mismatch("data_addr_o", data_addr_o, exp_addr);
		assert (data_wdata_o == exp_data) else
			report_mismatch("data_wdata_o", data_wdata_o, exp_data);
	endtask

	// instruction memory with 0 to 3 wait cycles
	always @(posedge clock) begin
		if (reset_i) begin
			inst_valid_i <= 1'b0;
			inst_busy    <= 1'b0;
			inst_left    <= 0;
		end else begin
			inst_valid_i <= 1'b0;
			// request seen in its valid cycle is already over
			if (inst_req_o && !inst_valid_i) begin
				if (inst_busy) begin
					inst_delay = inst_left;
				end else begin
					inst_rng   = xorshift32(inst_rng);
					inst_delay = inst_rng[1:0];
				end
				if (inst_delay == 0) begin
					assert (inst_addr_o[1:0] == 2'b00 && inst_addr_o < PROG_WORDS * 4) else
						stop_with_error("instruction fetch outside the program area");
					inst_valid_i <= 1'b1;
					inst_rdata_i <= imem[inst_addr_o[6:2]];
					inst_busy    <= 1'b0;
				end else begin
					inst_busy <= 1'b1;
					inst_left <= inst_delay - 1;
				end
			end
		end
	end

	// data memory with the same latency scheme
	// each store is compared when it completes
	always @(posedge clock) begin
		if (reset_i) begin
			data_valid_i <= 1'b0;
			data_busy    <= 1'b0;
			data_left    <= 0;
		end else begin
			data_valid_i <= 1'b0;
			if (data_req_o && !data_valid_i) begin
				if (data_busy) begin
					data_delay = data_left;
				end else begin
					data_rng   = xorshift32(data_rng);
					data_delay = data_rng[1:0];
				end
				if (data_delay == 0) begin
					assert (data_addr_o[1:0] == 2'b00 && data_addr_o < 32'h100) else
						stop_with_error("data access outside the data memory");
					data_valid_i <= 1'b1;
					data_busy    <= 1'b0;
					if (data_we_o) begin
						check_store();
						dmem[data_addr_o[7:2]] = data_wdata_o;
						store_count = store_count + 1;
					end else begin
						data_rdata_i <= dmem[data_addr_o[7:2]];
					end
				end else begin
					data_busy <= 1'b1;
					data_left <= data_delay - 1;
				end
			end
		end
	end

	initial begin
		clock        = 1'b0;
		reset_i      <= 1'b1;
		inst_valid_i <= 1'b0;
		inst_rdata_i <= '0;
		data_valid_i <= 1'b0;
		data_rdata_i <= '0;
		inst_rng     = 32'h4cc8;
		data_rng     = 32'h4cc8;
		store_count  = 0;
		$readmemh("testbench/core_golden.hex", golden);
		rec_count = golden[COUNT_INDEX];
		assert (rec_count > 0 && rec_count <= MAX_RECORDS) else
			stop_with_error("golden file gives no usable store record count");
		assert (golden[PROG_WORDS - 1] == `EBREAK_WORD) else
			stop_with_error("golden program does not end in ebreak");
		for (int i = 0; i < PROG_WORDS; i++) begin
			imem[i] = golden[i];
		end
		// fill carries the byte address
		for (int i = 0; i < 64; i++) begin
			dmem[i] = 32'hd00d_0000 | (i << 2);
		end
		for (int i = 0; i < DATA_WORDS; i++) begin
			dmem[i] = golden[DATA_BASE + i];
		end

		repeat (2) @(posedge clock);
		reset_i <= 1'b0;

		// first edge with reset low still shows reset outputs
		@(posedge clock);
		assert (inst_req_o == 1'b0) else report_mismatch("inst_req_o", inst_req_o, 0);
		assert (data_req_o == 1'b0) else report_mismatch("data_req_o", data_req_o, 0);
		assert (data_we_o == 1'b0) else report_mismatch("data_we_o", data_we_o, 0);
		assert (halted_o == 1'b0) else report_mismatch("halted_o", halted_o, 0);

		cycles = 0;
		while (inst_req_o !== 1'b1 && cycles < REQ_LIMIT) begin
			@(posedge clock);
			cycles++;
		end
		assert (inst_req_o === 1'b1) else
			stop_with_error("first instruction request did not appear after reset");
		assert (inst_addr_o == `RESET_PC) else
			report_mismatch("inst_addr_o", inst_addr_o, `RESET_PC);

		// program runs until ebreak
		// the data memory compares every store on the way
		cycles = 0;
		while (halted_o !== 1'b1 && cycles < HALT_LIMIT) begin
			@(posedge clock);
			cycles++;
		end
		assert (halted_o === 1'b1) else
			stop_with_error("core did not halt within the cycle limit");
		assert (store_count == rec_count) else
			report_mismatch("store_count", word_t'(store_count), word_t'(rec_count));

		// halted core stays quiet
		repeat (IDLE_CYCLES) begin
			@(posedge clock);
			assert (inst_req_o == 1'b0) else report_mismatch("inst_req_o", inst_req_o, 0);
			assert (data_req_o == 1'b0) else report_mismatch("data_req_o", data_req_o, 0);
			assert (halted_o == 1'b1) else report_mismatch("halted_o", halted_o, 1);
		end

		$display("Done: no errors");
		$finish;
	end

endmodule

`default_nettype wire

/* testbench/core_golden.hex */
// words 00-1f program, 20-23 initial data words at data address 0
// 28-3b store records as address then data, word 3f record count
@00
00500093 ffd00113 04000513 002081b3
40208233 123452b7 0012c333 001123b3
0041e433 0022f4b3 00352023 00452223
00652423 00752623 00852823 00952a23
00002603 00402683 00d60733 00e52c23
00108463 00152e23 00209463 00252e23
00208463 00152e23 00109463 02252023
008007ef 02052223 02f52223 00100073
@20
01020304 10203040 a5a5a5a5 5a5a5a5a
@28
00000040 00000002
00000044 00000008
00000048 12345005
0000004c 00000001
00000050 0000000a
00000054 12345000
00000058 11223344
0000005c 00000005
00000060 fffffffd
00000064 00000074
@3f
0000000a

/* sim.f */
+incdir+hdl
hdl/core_pkg.sv
hdl/fetch_unit.sv
hdl/decoder.sv
hdl/register_file.sv
hdl/exec_unit.sv
hdl/lsu_wb.sv
hdl/core_top.sv
testbench/core_tb.sv
